// ==== tests/program.hex ====
// one 32-bit instruction word per line, from address 0 upward
// assembly of each word follows it
123450b7 // lui  x1, 0x12345
67808113 // addi x2, x1, 0x678
001101b3 // add  x3, x2, x1
40118233 // sub  x4, x3, x1
001242b3 // xor  x5, x4, x1
0041f333 // and  x6, x3, x4
10603023 // sd   x6, 0x100(x0)
10103423 // sd   x1, 0x108(x0)
10203823 // sd   x2, 0x110(x0)
10303c23 // sd   x3, 0x118(x0)
12403023 // sd   x4, 0x120(x0)
12503423 // sd   x5, 0x128(x0)
800003b7 // lui  x7, 0x80000
12703823 // sd   x7, 0x130(x0)
08003403 // ld   x8, 0x80(x0)
002404b3 // add  x9, x8, x2
12903c23 // sd   x9, 0x138(x0)
00410463 // beq  x2, x4, +8
1e103823 // sd   x1, 0x1f0(x0)
00209463 // bne  x1, x2, +8
1e103823 // sd   x1, 0x1f0(x0)
00208463 // beq  x1, x2, +8
14503023 // sd   x5, 0x140(x0)
00411463 // bne  x2, x4, +8
14003423 // sd   x0, 0x148(x0)
0080056f // jal  x10, +8
1e103823 // sd   x1, 0x1f0(x0)
14a03823 // sd   x10, 0x150(x0)
00100593 // addi x11, x0, 1
1eb03c23 // sd   x11, 0x1f8(x0)
0000006f // jal  x0, 0

// ==== filelist.f ====
common/core_pkg.sv
pipeline/fetch.sv
pipeline/decode.sv
pipeline/execute.sv
pipeline/memory.sv
design/regfile.sv
design/hazard.sv
design/core.sv
tests/core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS ?= --timing --assert
TOP ?= core_tb
FILELIST ?= filelist.f
LOG ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== tests/core_tb.sv ====
`timescale 1ns/100ps

module core_tb;

	localparam logic [63:0] PC_INIT = 64'h0;
	localparam int RESET_CYCLES = 10;
	localparam int PROG_LEN = 31;
	// four cycles of fetch wait, four of data wait, plus stall and flush slots
	localparam int WORST_CPI = 16;
	localparam int MARGIN = 200;
	localparam int NUM_STORES = 11;
	localparam logic [63:0] LOAD_ADDR = 64'h80;
	localparam logic [63:0] POISON_ADDR = 64'h1f0;
	localparam logic [63:0] DONE_ADDR = 64'h1f8;

	localparam int T_RESET = 0;
	localparam int T_ALU = 1;
	localparam int T_LOAD = 2;
	localparam int T_BRANCH = 3;
	localparam int T_BUS = 4;
	localparam int T_DONE = 5;

	logic clk;
	logic reset;
	logic [63:0] ireq_addr;
	logic iresp_data_ok;
	logic [31:0] iresp_data;
	logic dreq_valid;
	logic [63:0] dreq_addr;
	logic dreq_write;
	logic [63:0] dreq_data;
	logic [7:0] dreq_strobe;
	logic dresp_data_ok;
	logic [63:0] dresp_data;

	logic [31:0] imem [64];
	logic [63:0] dmem [64];
	logic [63:0] exp_addr [NUM_STORES];
	logic [63:0] exp_data [NUM_STORES];
	string names [6];
	int fails [6];
	logic [5:0] reported;
	int passed;
	int failed;
	int store_idx;
	logic seen_iok;
	logic done_seen;
	logic [31:0] lfsr;
	logic [1:0] iwait;
	logic [1:0] dwait;
	logic data_store;
	logic done_store;

	core #(.PC_INIT(PC_INIT)) u_core (
		.clk, .reset,
		.ireq_addr, .iresp_data_ok, .iresp_data,
		.dreq_valid, .dreq_addr, .dreq_write, .dreq_data, .dreq_strobe,
		.dresp_data_ok, .dresp_data
	);

	always #10 clk = ~clk;

	function automatic logic [31:0] lfsr_step(logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// one LFSR step per latency bit
	function automatic logic [1:0] draw_latency();
		logic [1:0] v;
		lfsr = lfsr_step(lfsr);
		v[0] = lfsr[0];
		lfsr = lfsr_step(lfsr);
		v[1] = lfsr[0];
		return v;
	endfunction

	function automatic logic [63:0] fill_word(int i);
		return {32'hcafe_0000 + 32'(i), 32'h5a5a_0000 + 32'(i)};
	endfunction

	task automatic report_test(int t);
		reported[t] = 1'b1;
		if (fails[t] == 0) begin
			passed++;
			$display("test %s: PASS", names[t]);
		end else begin
			failed++;
			$display("test %s: FAIL (%0d errors)", names[t], fails[t]);
		end
	endtask

	function automatic int group_of(int idx);
		if (idx < 7)
			return T_ALU;
		if (idx < 8)
			return T_LOAD;
		return T_BRANCH;
	endfunction

	// both memory models answer after 0 to 3 cycles
	always @(negedge clk) begin
		if (reset) begin
			iresp_data_ok = 1'b0;
			dresp_data_ok = 1'b0;
		end else begin
			if (iwait == 2'd0) begin
				iresp_data_ok = 1'b1;
				iresp_data = imem[ireq_addr[7:2]];
				iwait = draw_latency();
			end else begin
				iresp_data_ok = 1'b0;
				iwait = iwait - 2'd1;
			end
			if (!dreq_valid) begin
				dresp_data_ok = 1'b0;
			end else if (dwait == 2'd0) begin
				dresp_data_ok = 1'b1;
				dresp_data = dreq_write ? 64'h0 : dmem[dreq_addr[8:3]];
				dwait = draw_latency();
			end else begin
				dresp_data_ok = 1'b0;
				dwait = dwait - 2'd1;
			end
		end
	end

	assign data_store = dreq_valid && dreq_write && dresp_data_ok && dreq_addr != DONE_ADDR;
	assign done_store = dreq_valid && dreq_write && dresp_data_ok && dreq_addr == DONE_ADDR;

	always @(posedge clk) begin
		if (!reset) begin
			if (iresp_data_ok)
				seen_iok <= 1'b1;
			if (dreq_valid && dreq_write && dresp_data_ok)
				dmem[dreq_addr[8:3]] <= dreq_data;
			if (data_store)
				store_idx <= store_idx + 1;
			if (done_store)
				done_seen <= 1'b1;
		end
	end

	// a test closes half a cycle after its last checked edge
	always @(negedge clk) begin
		if (seen_iok && !reported[T_RESET])
			report_test(T_RESET);
		if (store_idx >= 7 && !reported[T_ALU])
			report_test(T_ALU);
		if (store_idx >= 8 && !reported[T_LOAD])
			report_test(T_LOAD);
		if (store_idx >= NUM_STORES && !reported[T_BRANCH])
			report_test(T_BRANCH);
	end

	reset_state: assert property (@(posedge clk) disable iff (reset)
		!seen_iok |-> !dreq_valid && ireq_addr == PC_INIT)
		else begin
			fails[T_RESET]++;
			$display("Mismatch %s: expected ireq_addr 0x%0h, actual 0x%0h", names[T_RESET],
				PC_INIT, ireq_addr);
		end

	ireq_stable: assert property (@(posedge clk) disable iff (reset)
		!iresp_data_ok |=> $stable(ireq_addr))
		else begin
			fails[T_BUS]++;
			$display("%s: instruction address changed before data_ok", names[T_BUS]);
		end

	dreq_stable: assert property (@(posedge clk) disable iff (reset)
		dreq_valid && !dresp_data_ok |=> dreq_valid && $stable(dreq_addr)
			&& $stable(dreq_write) && $stable(dreq_data) && $stable(dreq_strobe))
		else begin
			fails[T_BUS]++;
			$display("%s: data request dropped or changed while waiting", names[T_BUS]);
		end

	// the program's only load reads LOAD_ADDR, every other access is an sd
	strobe_ok: assert property (@(posedge clk) disable iff (reset)
		dreq_valid |-> dreq_write == (dreq_addr != LOAD_ADDR)
			&& dreq_strobe == ((dreq_addr == LOAD_ADDR) ? 8'h00 : 8'hff))
		else begin
			fails[T_BUS]++;
			$display("Mismatch %s: expected write %0b strobe 0x%0h, actual write %0b strobe 0x%0h",
				names[T_BUS], dreq_addr != LOAD_ADDR,
				(dreq_addr == LOAD_ADDR) ? 8'h00 : 8'hff, dreq_write, dreq_strobe);
		end

	no_poison: assert property (@(posedge clk) disable iff (reset)
		dreq_valid && dreq_write |-> dreq_addr != POISON_ADDR)
		else begin
			fails[T_BRANCH]++;
			$display("%s: a shadow store reached the poison address", names[T_BRANCH]);
		end

	store_in_table: assert property (@(posedge clk) disable iff (reset)
		data_store |-> store_idx < NUM_STORES)
		else begin
			fails[T_DONE]++;
			$display("%s: more stores than expected", names[T_DONE]);
		end

	store_addr: assert property (@(posedge clk) disable iff (reset)
		data_store && store_idx < NUM_STORES |-> dreq_addr == exp_addr[store_idx])
		else begin
			fails[group_of(store_idx)]++;
			$display("Mismatch %s: expected addr 0x%0h, actual 0x%0h",
				names[group_of(store_idx)], exp_addr[store_idx], dreq_addr);
		end

	store_data: assert property (@(posedge clk) disable iff (reset)
		data_store && store_idx < NUM_STORES |-> dreq_data == exp_data[store_idx])
		else begin
			fails[group_of(store_idx)]++;
			$display("Mismatch %s: expected data 0x%0h, actual 0x%0h",
				names[group_of(store_idx)], exp_data[store_idx], dreq_data);
		end

	done_once: assert property (@(posedge clk) disable iff (reset)
		done_store |-> !done_seen && store_idx == NUM_STORES)
		else begin
			fails[T_DONE]++;
			$display("Mismatch %s: expected count %0d, actual %0d", names[T_DONE],
				NUM_STORES, store_idx);
		end

	// watchdog sized from the program length
	initial begin
		repeat (RESET_CYCLES + PROG_LEN * WORST_CPI + MARGIN) @(posedge clk);
		$display("Timeout: done store never seen");
		$display("Test failures found");
		$finish;
	end

	initial begin
		int errors;
		clk = 1'b0;
		reset = 1'b1;
		iresp_data_ok = 1'b0;
		iresp_data = 32'h0000_0013;
		dresp_data_ok = 1'b0;
		dresp_data = 64'h0;
		lfsr = 32'h7e3b58a1;
		iwait = 2'd0;
		dwait = 2'd0;
		store_idx = 0;
		seen_iok = 1'b0;
		done_seen = 1'b0;
		reported = '0;
		passed = 0;
		failed = 0;
		names = '{"reset_state", "alu_chain", "load_use", "branch_jal", "bus_protocol",
			"done_store"};
		for (int i = 0; i < 6; i++)
			fails[i] = 0;
		for (int i = 0; i < 64; i++) begin
			imem[i] = 32'h0000_0013;
			dmem[i] = fill_word(i);
		end
		$readmemh("tests/program.hex", imem);

		exp_addr[0] = 64'h100;
		exp_data[0] = 64'h0020_0678;
		exp_addr[1] = 64'h108;
		exp_data[1] = 64'h1234_5000;
		exp_addr[2] = 64'h110;
		exp_data[2] = 64'h1234_5678;
		exp_addr[3] = 64'h118;
		exp_data[3] = 64'h2468_a678;
		exp_addr[4] = 64'h120;
		exp_data[4] = 64'h1234_5678;
		exp_addr[5] = 64'h128;
		exp_data[5] = 64'h678;
		// lui sign extends bit 31
		exp_addr[6] = 64'h130;
		exp_data[6] = 64'hffff_ffff_8000_0000;
		// fill word at index 16 plus x2
		exp_addr[7] = 64'h138;
		exp_data[7] = 64'hcafe_0010_6c8e_5688;
		exp_addr[8] = 64'h140;
		exp_data[8] = 64'h678;
		exp_addr[9] = 64'h148;
		exp_data[9] = 64'h0;
		// link of the jal at 0x64
		exp_addr[10] = 64'h150;
		exp_data[10] = 64'h68;

		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset <= 1'b0;

		wait (done_seen);
		repeat (4) @(negedge clk);
		report_test(T_BUS);
		report_test(T_DONE);
		errors = 0;
		for (int i = 0; i < 6; i++)
			errors += fails[i];
		$display("tests: %0d passed, %0d failed, %0d stores", passed, failed, store_idx);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// ==== design/core.sv ====
`timescale 1ns/100ps

module core #(
	parameter core_pkg::u64 PC_INIT = 64'h0
) (
	input logic clk,
	input logic reset,
	output core_pkg::u64 ireq_addr,
	input logic iresp_data_ok,
	input core_pkg::u32 iresp_data,
	output logic dreq_valid,
	output core_pkg::u64 dreq_addr,
	output logic dreq_write,
	output core_pkg::u64 dreq_data,
	output logic [7:0] dreq_strobe,
	input logic dresp_data_ok,
	input core_pkg::u64 dresp_data
);
	import core_pkg::*;

	logic stall_f;
	logic stall_d;
	logic stall_e;
	logic stall_m;
	logic flush_d;
	logic flush_e;
	logic flush_m;
	logic redirect;
	u64 redirect_pc;

	logic d_valid;
	u64 d_pc;
	u32 d_instr;
	u5 rs1;
	u5 rs2;
	u64 rs1_data;
	u64 rs2_data;
	fwd_sel_t fwd_a;
	fwd_sel_t fwd_b;

	logic e_valid;
	u64 e_pc;
	alu_op_t e_op;
	u64 e_a;
	u64 e_b;
	u64 e_imm;
	u64 e_store_data;
	u5 e_rd;
	logic e_load;
	logic e_store;
	logic e_branch;
	logic e_branch_ne;
	logic e_jal;
	logic e_use_imm;
	logic e_wen;
	u64 ex_result;

	logic m_valid;
	u64 m_result;
	u64 m_store_data;
	u5 m_rd;
	logic m_load;
	logic m_store;
	logic m_wen;
	u64 mem_result;
	logic wb_en;
	u5 wb_addr;
	u64 wb_data;

	fetch #(.PC_INIT(PC_INIT)) u_fetch (
		.clk, .reset,
		.stall(stall_f), .flush(flush_d),
		.redirect, .redirect_pc,
		.instr_ok(iresp_data_ok), .instr_data(iresp_data),
		.pc(ireq_addr),
		.d_valid, .d_pc, .d_instr
	);

	decode u_decode (
		.clk, .reset,
		.stall(stall_d), .flush(flush_e),
		.d_valid, .d_pc, .d_instr,
		.rs1_data, .rs2_data, .fwd_a, .fwd_b,
		.ex_result, .mem_result, .wb_data,
		.rs1, .rs2,
		.e_valid, .e_pc, .e_op, .e_a, .e_b, .e_imm, .e_store_data, .e_rd,
		.e_load, .e_store, .e_branch, .e_branch_ne, .e_jal, .e_use_imm, .e_wen
	);

	execute u_execute (
		.clk, .reset,
		.stall(stall_e), .flush(flush_m),
		.e_valid, .e_pc, .e_op, .e_a, .e_b, .e_imm, .e_store_data, .e_rd,
		.e_load, .e_store, .e_branch, .e_branch_ne, .e_jal, .e_use_imm, .e_wen,
		.ex_result, .redirect, .redirect_pc,
		.m_valid, .m_result, .m_store_data, .m_rd, .m_load, .m_store, .m_wen
	);

	memory u_memory (
		.clk, .reset,
		.stall(stall_m),
		.m_valid, .m_result, .m_store_data, .m_rd, .m_load, .m_store, .m_wen,
		.dresp_data_ok, .dresp_data,
		.dreq_valid, .dreq_addr, .dreq_write, .dreq_data, .dreq_strobe,
		.mem_result, .wb_en, .wb_addr, .wb_data
	);

	regfile u_regfile (
		.clk, .reset,
		.rs1, .rs2,
		.wb_en, .wb_addr, .wb_data,
		.rs1_data, .rs2_data
	);

	hazard u_hazard (
		.rs1, .rs2,
		.e_rd, .e_wen, .e_load,
		.m_rd, .m_wen,
		.wb_addr, .wb_en,
		.instr_ok(iresp_data_ok), .dreq_valid, .dresp_data_ok, .redirect,
		.fwd_a, .fwd_b,
		.stall_f, .stall_d, .stall_e, .stall_m,
		.flush_d, .flush_e, .flush_m
	);

endmodule

// ==== design/hazard.sv ====
`timescale 1ns/100ps

module hazard (
	input core_pkg::u5 rs1,
	input core_pkg::u5 rs2,
	input core_pkg::u5 e_rd,
	input logic e_wen,
	input logic e_load,
	input core_pkg::u5 m_rd,
	input logic m_wen,
	input core_pkg::u5 wb_addr,
	input logic wb_en,
	input logic instr_ok,
	input logic dreq_valid,
	input logic dresp_data_ok,
	input logic redirect,
	output core_pkg::fwd_sel_t fwd_a,
	output core_pkg::fwd_sel_t fwd_b,
	output logic stall_f,
	output logic stall_d,
	output logic stall_e,
	output logic stall_m,
	output logic flush_d,
	output logic flush_e,
	output logic flush_m
);
	import core_pkg::*;

	logic mem_wait;
	logic load_use;
	logic br_wait;
	logic br_go;

	// youngest writer wins
	function automatic fwd_sel_t source(u5 rs, u5 ex_rd, logic ex_ok, u5 mem_rd,
		logic mem_ok, u5 last_rd, logic last_ok);
		if (rs == 5'd0)
			return FWD_RF;
		if (ex_ok && ex_rd == rs)
			return FWD_EX;
		if (mem_ok && mem_rd == rs)
			return FWD_MEM;
		if (last_ok && last_rd == rs)
			return FWD_WB;
		return FWD_RF;
	endfunction

	assign fwd_a = source(rs1, e_rd, e_wen && !e_load, m_rd, m_wen, wb_addr, wb_en);
	assign fwd_b = source(rs2, e_rd, e_wen && !e_load, m_rd, m_wen, wb_addr, wb_en);

	assign mem_wait = dreq_valid && !dresp_data_ok;
	assign load_use = e_load && e_wen && (e_rd == rs1 || e_rd == rs2);

	// fetch address may only change once the pending word has arrived
	assign br_wait = redirect && !instr_ok;
	assign br_go = redirect && instr_ok && !mem_wait;

	// stall_x holds stage x, flush_x empties the register feeding stage x
	assign stall_m = mem_wait;
	assign stall_e = mem_wait;
	assign stall_d = mem_wait || br_wait;
	assign stall_f = mem_wait || br_wait || load_use;
	assign flush_m = !mem_wait && br_wait;
	assign flush_e = !mem_wait && (load_use || br_go);
	assign flush_d = br_go;

	// loads and taken branches never sit in execute together
	always_comb begin
		no_flush_on_hold: assert final (!(flush_d && stall_f) && !(flush_e && stall_d)
			&& !(flush_m && stall_e));
	end

endmodule

// ==== design/regfile.sv ====
`timescale 1ns/100ps

module regfile (
	input logic clk,
	input logic reset,
	input core_pkg::u5 rs1,
	input core_pkg::u5 rs2,
	input logic wb_en,
	input core_pkg::u5 wb_addr,
	input core_pkg::u64 wb_data,
	output core_pkg::u64 rs1_data,
	output core_pkg::u64 rs2_data
);
	import core_pkg::*;

	u64 regs [32];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (wb_en && wb_addr != 5'd0) begin
			regs[wb_addr] <= wb_data;
		end
	end

	// same-cycle writes reach decode through the WB forward path
	assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
	assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

// ==== pipeline/memory.sv ====
`timescale 1ns/100ps

module memory (
	input logic clk,
	input logic reset,
	input logic stall,
	input logic m_valid,
	input core_pkg::u64 m_result,
	input core_pkg::u64 m_store_data,
	input core_pkg::u5 m_rd,
	input logic m_load,
	input logic m_store,
	input logic m_wen,
	input logic dresp_data_ok,
	input core_pkg::u64 dresp_data,
	output logic dreq_valid,
	output core_pkg::u64 dreq_addr,
	output logic dreq_write,
	output core_pkg::u64 dreq_data,
	output logic [7:0] dreq_strobe,
	output core_pkg::u64 mem_result,
	output logic wb_en,
	output core_pkg::u5 wb_addr,
	output core_pkg::u64 wb_data
);

	// request is driven straight from the execute register, held there while waiting
	assign dreq_valid = m_valid && (m_load || m_store);
	assign dreq_addr = m_result;
	assign dreq_write = m_store;
	assign dreq_data = m_store_data;
	assign dreq_strobe = m_store ? 8'hff : 8'h00;

	assign mem_result = m_load ? dresp_data : m_result;

	// a waiting access sends a bubble on to writeback
	always_ff @(posedge clk) begin
		if (reset)
			wb_en <= 1'b0;
		else
			wb_en <= !stall && m_valid && m_wen;
	end

	always_ff @(posedge clk) begin
		wb_addr <= m_rd;
		wb_data <= mem_result;
	end

	req_stable: assert property (@(posedge clk) disable iff (reset)
		dreq_valid && !dresp_data_ok |=> dreq_valid && $stable(dreq_addr)
			&& $stable(dreq_write) && $stable(dreq_data) && $stable(dreq_strobe));

endmodule

// ==== pipeline/execute.sv ====
`timescale 1ns/100ps

module execute (
	input logic clk,
	input logic reset,
	input logic stall,
	input logic flush,
	input logic e_valid,
	input core_pkg::u64 e_pc,
	input core_pkg::alu_op_t e_op,
	input core_pkg::u64 e_a,
	input core_pkg::u64 e_b,
	input core_pkg::u64 e_imm,
	input core_pkg::u64 e_store_data,
	input core_pkg::u5 e_rd,
	input logic e_load,
	input logic e_store,
	input logic e_branch,
	input logic e_branch_ne,
	input logic e_jal,
	input logic e_use_imm,
	input logic e_wen,
	output core_pkg::u64 ex_result,
	output logic redirect,
	output core_pkg::u64 redirect_pc,
	output logic m_valid,
	output core_pkg::u64 m_result,
	output core_pkg::u64 m_store_data,
	output core_pkg::u5 m_rd,
	output logic m_load,
	output logic m_store,
	output logic m_wen
);
	import core_pkg::*;

	u64 op_b;
	u64 alu_out;
	logic taken;

	assign op_b = e_use_imm ? e_imm : e_b;

	always_comb begin
		case (e_op)
			ALU_SUB: alu_out = e_a - op_b;
			ALU_AND: alu_out = e_a & op_b;
			ALU_OR: alu_out = e_a | op_b;
			ALU_XOR: alu_out = e_a ^ op_b;
			ALU_PASSB: alu_out = op_b;
			default: alu_out = e_a + op_b;
		endcase
	end

	// jal writes the link address
	assign ex_result = e_jal ? e_pc + 64'd4 : alu_out;

	// bne inverts the equality test
	assign taken = e_branch && ((e_a == e_b) != e_branch_ne);
	assign redirect = e_valid && (taken || e_jal);
	assign redirect_pc = e_pc + e_imm;

	always_ff @(posedge clk) begin
		if (reset) begin
			m_valid <= 1'b0;
			m_load <= 1'b0;
			m_store <= 1'b0;
			m_wen <= 1'b0;
		end else if (!stall) begin
			m_valid <= e_valid && !flush;
			m_load <= e_load && !flush;
			m_store <= e_store && !flush;
			m_wen <= e_wen && !flush;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			m_result <= ex_result;
			m_store_data <= e_store_data;
			m_rd <= e_rd;
		end
	end

endmodule

// ==== pipeline/decode.sv ====
`timescale 1ns/100ps

module decode (
	input logic clk,
	input logic reset,
	input logic stall,
	input logic flush,
	input logic d_valid,
	input core_pkg::u64 d_pc,
	input core_pkg::u32 d_instr,
	input core_pkg::u64 rs1_data,
	input core_pkg::u64 rs2_data,
	input core_pkg::fwd_sel_t fwd_a,
	input core_pkg::fwd_sel_t fwd_b,
	input core_pkg::u64 ex_result,
	input core_pkg::u64 mem_result,
	input core_pkg::u64 wb_data,
	output core_pkg::u5 rs1,
	output core_pkg::u5 rs2,
	output logic e_valid,
	output core_pkg::u64 e_pc,
	output core_pkg::alu_op_t e_op,
	output core_pkg::u64 e_a,
	output core_pkg::u64 e_b,
	output core_pkg::u64 e_imm,
	output core_pkg::u64 e_store_data,
	output core_pkg::u5 e_rd,
	output logic e_load,
	output logic e_store,
	output logic e_branch,
	output logic e_branch_ne,
	output logic e_jal,
	output logic e_use_imm,
	output logic e_wen
);
	import core_pkg::*;

	instr_t ins;
	logic [2:0] funct3;
	logic known;
	logic uses_rs1;
	logic uses_rs2;
	logic writes_rd;
	logic is_load;
	logic is_store;
	logic is_branch;
	logic is_jal;
	logic use_imm;
	logic live;
	alu_op_t op;
	u64 imm;
	u64 a_val;
	u64 b_val;

	function automatic u64 pick(fwd_sel_t sel, u64 rf, u64 ex, u64 mem, u64 wb);
		case (sel)
			FWD_EX: return ex;
			FWD_MEM: return mem;
			FWD_WB: return wb;
			default: return rf;
		endcase
	endfunction

	// an empty slot decodes as the canonical nop, so its register fields read x0
	assign ins = d_valid ? d_instr : NOP_INSTR;
	assign funct3 = ins.r_fmt.funct3;

	always_comb begin
		known = 1'b0;
		uses_rs1 = 1'b0;
		uses_rs2 = 1'b0;
		writes_rd = 1'b0;
		is_load = 1'b0;
		is_store = 1'b0;
		is_branch = 1'b0;
		is_jal = 1'b0;
		use_imm = 1'b0;
		op = ALU_ADD;
		imm = '0;
		case (ins.r_fmt.opcode)
			OP_LUI: begin
				known = 1'b1;
				writes_rd = 1'b1;
				use_imm = 1'b1;
				op = ALU_PASSB;
				imm = {{32{ins.u_fmt.imm[19]}}, ins.u_fmt.imm, 12'h000};
			end
			OP_IMM: begin
				known = funct3 == 3'b000;
				uses_rs1 = 1'b1;
				writes_rd = 1'b1;
				use_imm = 1'b1;
				imm = {{52{ins.i_fmt.imm[11]}}, ins.i_fmt.imm};
			end
			OP_REG: begin
				known = 1'b1;
				uses_rs1 = 1'b1;
				uses_rs2 = 1'b1;
				writes_rd = 1'b1;
				case (funct3)
					3'b000: op = ins.r_fmt.funct7[5] ? ALU_SUB : ALU_ADD;
					3'b100: op = ALU_XOR;
					3'b110: op = ALU_OR;
					3'b111: op = ALU_AND;
					default: known = 1'b0;
				endcase
			end
			OP_LOAD: begin
				known = funct3 == 3'b011;
				uses_rs1 = 1'b1;
				writes_rd = 1'b1;
				is_load = 1'b1;
				use_imm = 1'b1;
				imm = {{52{ins.i_fmt.imm[11]}}, ins.i_fmt.imm};
			end
			OP_STORE: begin
				known = funct3 == 3'b011;
				uses_rs1 = 1'b1;
				uses_rs2 = 1'b1;
				is_store = 1'b1;
				use_imm = 1'b1;
				imm = {{52{ins.s_fmt.imm_hi[6]}}, ins.s_fmt.imm_hi, ins.s_fmt.imm_lo};
			end
			OP_BRANCH: begin
				// beq and bne only
				known = funct3[2:1] == 2'b00;
				uses_rs1 = 1'b1;
				uses_rs2 = 1'b1;
				is_branch = 1'b1;
				imm = {{51{ins.b_fmt.imm12}}, ins.b_fmt.imm12, ins.b_fmt.imm11,
					ins.b_fmt.imm10_5, ins.b_fmt.imm4_1, 1'b0};
			end
			OP_JAL: begin
				known = 1'b1;
				writes_rd = 1'b1;
				is_jal = 1'b1;
				imm = {{43{ins.j_fmt.imm20}}, ins.j_fmt.imm20, ins.j_fmt.imm19_12,
					ins.j_fmt.imm11, ins.j_fmt.imm10_1, 1'b0};
			end
			default: begin
			end
		endcase
	end

	// unused source fields read as x0 so they never match a hazard
	assign rs1 = (known && uses_rs1) ? ins.r_fmt.rs1 : 5'd0;
	assign rs2 = (known && uses_rs2) ? ins.r_fmt.rs2 : 5'd0;

	assign a_val = pick(fwd_a, rs1_data, ex_result, mem_result, wb_data);
	assign b_val = pick(fwd_b, rs2_data, ex_result, mem_result, wb_data);

	assign live = d_valid && known && !flush;

	always_ff @(posedge clk) begin
		if (reset) begin
			e_valid <= 1'b0;
			e_load <= 1'b0;
			e_store <= 1'b0;
			e_branch <= 1'b0;
			e_branch_ne <= 1'b0;
			e_jal <= 1'b0;
			e_wen <= 1'b0;
		end else if (!stall) begin
			e_valid <= live;
			e_load <= live && is_load;
			e_store <= live && is_store;
			e_branch <= live && is_branch;
			e_branch_ne <= live && is_branch && funct3[0];
			e_jal <= live && is_jal;
			e_wen <= live && writes_rd && (ins.r_fmt.rd != 5'd0);
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			e_pc <= d_pc;
			e_op <= op;
			e_a <= a_val;
			e_b <= b_val;
			e_imm <= imm;
			e_store_data <= b_val;
			e_rd <= ins.r_fmt.rd;
			e_use_imm <= use_imm;
		end
	end

endmodule

// ==== pipeline/fetch.sv ====
`timescale 1ns/100ps

module fetch #(
	parameter core_pkg::u64 PC_INIT = 64'h0
) (
	input logic clk,
	input logic reset,
	input logic stall,
	input logic flush,
	input logic redirect,
	input core_pkg::u64 redirect_pc,
	input logic instr_ok,
	input core_pkg::u32 instr_data,
	output core_pkg::u64 pc,
	output logic d_valid,
	output core_pkg::u64 d_pc,
	output core_pkg::u32 d_instr
);
	import core_pkg::*;

	// pc only moves once the bus has answered, so the request address stays put
	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= PC_INIT;
			d_valid <= 1'b0;
			d_instr <= NOP_INSTR;
		end else if (!stall) begin
			if (flush) begin
				d_valid <= 1'b0;
				d_instr <= NOP_INSTR;
				if (redirect)
					pc <= redirect_pc;
			end else if (instr_ok) begin
				d_valid <= 1'b1;
				d_instr <= instr_data;
				pc <= pc + 64'd4;
			end else begin
				d_valid <= 1'b0;
				d_instr <= NOP_INSTR;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!stall && !flush && instr_ok)
			d_pc <= pc;
	end

	// branch and jal targets from execute keep the fetch address word aligned
	pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00);

endmodule

// ==== common/core_pkg.sv ====
package core_pkg;

	parameter int XLEN = 64;

	typedef logic [XLEN-1:0] u64;
	typedef logic [31:0] u32;
	typedef logic [4:0] u5;

	// base opcodes, funct3 is checked in decode
	parameter logic [6:0] OP_LUI = 7'b0110111;
	parameter logic [6:0] OP_IMM = 7'b0010011;
	parameter logic [6:0] OP_REG = 7'b0110011;
	parameter logic [6:0] OP_LOAD = 7'b0000011;
	parameter logic [6:0] OP_STORE = 7'b0100011;
	parameter logic [6:0] OP_BRANCH = 7'b1100011;
	parameter logic [6:0] OP_JAL = 7'b1101111;

	// addi x0, x0, 0
	parameter u32 NOP_INSTR = 32'h0000_0013;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_PASSB
	} alu_op_t;

	typedef enum logic [1:0] {
		FWD_RF,
		FWD_EX,
		FWD_MEM,
		FWD_WB
	} fwd_sel_t;

	typedef struct packed {
		logic [6:0] funct7;
		u5 rs2;
		u5 rs1;
		logic [2:0] funct3;
		u5 rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		u5 rs1;
		logic [2:0] funct3;
		u5 rd;
		logic [6:0] opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		u5 rs2;
		u5 rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} s_fmt_t;

	typedef struct packed {
		logic imm12;
		logic [5:0] imm10_5;
		u5 rs2;
		u5 rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic imm11;
		logic [6:0] opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm;
		u5 rd;
		logic [6:0] opcode;
	} u_fmt_t;

	typedef struct packed {
		logic imm20;
		logic [9:0] imm10_1;
		logic imm11;
		logic [7:0] imm19_12;
		u5 rd;
		logic [6:0] opcode;
	} j_fmt_t;

	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
		s_fmt_t s_fmt;
		b_fmt_t b_fmt;
		u_fmt_t u_fmt;
		j_fmt_t j_fmt;
	} instr_t;

endpackage
